// File: tb/diff_trace.txt
# Matrix header   M modulo size_i size_j   (hex)
# Element         E data expected          (hex, row-major)

# 2x3 mod 7 with elements above M and wrapped differences
M 0007 0002 0003
E 000a 0003
E 0003 0000
E 0014 0003
E 0005 0005
E 000f 0003
E 0002 0001

# 1x1 mod 13
M 000d 0001 0001
E 0064 0009

# 1x4 mod 1 gives all zero
M 0001 0001 0004
E 1234 0000
E ffff 0000
E 0000 0000
E 0007 0000

# 3x1 mod 256 where every element starts a row
M 0100 0003 0001
E 1234 0034
E 00ff 00ff
E abcd 00cd

# 2x3 with modulus near full width
M fff1 0002 0003
E ffff 000e
E 0005 ffe8
E fff0 ffeb
E fff2 0001
E fff1 fff0
E 8000 8000

# 3x2 mod 10
M 000a 0003 0002
E 002a 0002
E 0011 0005
E 0009 0009
E 0003 0004
E 0064 0000
E 0063 0009

# 1x3 mod 0x8000
M 8000 0001 0003
E ffff 7fff
E 0001 0002
E 8000 7fff

// File: list.f
hdl/diff_pkg.sv
hdl/mod_op_if.sv
hdl/mod_reducer.sv
hdl/mod_subtractor.sv
hdl/matrix_diff_ctrl.sv
hdl/matrix_diff_top.sv
tb/matrix_diff_checker.sv
tb/matrix_diff_tb.sv

// File: Makefile
# Verilator build and run for the matrix differentiation engine

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= matrix_diff_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search the log for the fail message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "TEST FAILED"; \
	  exit 1; \
	else \
	  echo "TEST PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/matrix_diff_tb.sv
//////////////////////////////////////////////////
// Matrix differentiation testbench
// Trace driven stimulus with watchdog and verdict
//////////////////////////////////////////////////

module matrix_diff_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DW = 16;

  // DUT connections
  logic          CLK;
  logic          RST;
  logic          start;
  logic          din_i_en;
  logic          din_j_en;
  logic [DW-1:0] modulo_in;
  logic [DW-1:0] size_i_in;
  logic [DW-1:0] size_j_in;
  logic [DW-1:0] data_in;
  logic          ready;
  logic          dout_i_en;
  logic          dout_j_en;
  logic [DW-1:0] data_out;

  // Modulo, rows and cols per matrix, flattened
  logic [DW-1:0] mat_q[$];
  // Data and expected result per element, flattened
  logic [DW-1:0] elem_q[$];
  int            tb_errors;
  int            limit_ns;

  matrix_diff_top #(.DATA_SIZE(DW)) dut0 (
    .CLK               (CLK),
    .RST               (RST),
    .START             (start),
    .DATA_IN_I_ENABLE  (din_i_en),
    .DATA_IN_J_ENABLE  (din_j_en),
    .MODULO_IN         (modulo_in),
    .SIZE_I_IN         (size_i_in),
    .SIZE_J_IN         (size_j_in),
    .DATA_IN           (data_in),
    .READY             (ready),
    .DATA_OUT_I_ENABLE (dout_i_en),
    .DATA_OUT_J_ENABLE (dout_j_en),
    .DATA_OUT          (data_out)
  );

  matrix_diff_checker #(.DATA_SIZE(DW)) chk0 (
    .CLK       (CLK),
    .RST       (RST),
    .ready     (ready),
    .dout_i_en (dout_i_en),
    .dout_j_en (dout_j_en),
    .data_out  (data_out)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Trace and stimulus
  //////////////////////////////////////////////////

  task automatic load_trace();
    int            fd;
    string         line;
    logic [DW-1:0] a;
    logic [DW-1:0] b;
    logic [DW-1:0] c;
    fd = $fopen("tb/diff_trace.txt", "r");
    if (fd == 0) begin
      $display("ERROR: trace file tb/diff_trace.txt could not be opened");
      tb_errors++;
      return;
    end
    // Comment and blank lines match neither tag
    while ($fgets(line, fd) != 0) begin
      if (line.getc(0) == "M" && $sscanf(line, "M %h %h %h", a, b, c) == 3) begin
        mat_q.push_back(a);
        mat_q.push_back(b);
        mat_q.push_back(c);
      end else if (line.getc(0) == "E" && $sscanf(line, "E %h %h", a, b) == 2) begin
        elem_q.push_back(a);
        elem_q.push_back(b);
      end
    end
    $fclose(fd);
  endtask

  // One matrix in row-major order, one element in flight
  task automatic run_matrix();
    int            rows;
    int            cols;
    logic [DW-1:0] d;
    @(posedge CLK);
    #1;
    modulo_in = mat_q.pop_front();
    size_i_in = mat_q.pop_front();
    size_j_in = mat_q.pop_front();
    rows = int'(size_i_in);
    cols = int'(size_j_in);
    start = 1'b1;
    @(posedge CLK);
    #1;
    start = 1'b0;
    for (int i = 0; i < rows; i++) begin
      for (int j = 0; j < cols; j++) begin
        if (elem_q.size() < 2) begin
          $display("ERROR: trace ends in the middle of a matrix");
          tb_errors++;
          return;
        end
        d = elem_q.pop_front();
        chk0.add_expect(elem_q.pop_front(), j == cols - 1, i == rows - 1 && j == cols - 1);
        @(posedge CLK);
        #1;
        data_in  = d;
        din_i_en = (j == 0);
        din_j_en = (j != 0);
        @(posedge CLK);
        #1;
        din_i_en = 1'b0;
        din_j_en = 1'b0;
        // Stray enables and junk data while in REDUCE
        if ($urandom_range(1, 0) == 1) begin
          repeat (2) @(posedge CLK);
          #1;
          data_in  = ~d;
          din_i_en = 1'b1;
          din_j_en = 1'b1;
          @(posedge CLK);
          #1;
          din_i_en = 1'b0;
          din_j_en = 1'b0;
        end
        do @(negedge CLK); while (!dout_j_en);
        repeat ($urandom_range(3, 0)) @(posedge CLK);
      end
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d mismatch, %0d protocol, %0d testbench (%0d results matched)",
             chk0.mismatch_cnt, chk0.protocol_cnt, tb_errors, chk0.match_cnt);
  endtask

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  // Worst element about DW+8 cycles, margin covers reset and headers
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("ERROR: watchdog expired after %0d ns with no result strobe", limit_ns);
    report_counts();
    $display("Simulation failed");
    $finish;
  end

  initial begin
    RST       = 1'b1;
    start     = 1'b0;
    din_i_en  = 1'b0;
    din_j_en  = 1'b0;
    modulo_in = '0;
    size_i_in = '0;
    size_j_in = '0;
    data_in   = '0;
    tb_errors = 0;
    limit_ns  = 0;
    void'($urandom(89));
    load_trace();
    if (mat_q.size() == 0) begin
      $display("ERROR: trace holds no matrix header");
      tb_errors++;
    end
    limit_ns = (elem_q.size() / 2) * (DW + 10) * 10 + mat_q.size() * 100 + 1000;
    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b0;
    // Outputs must stay quiet before the first START
    repeat (4) @(posedge CLK);
    while (mat_q.size() >= 3) begin
      run_matrix();
      repeat (3) @(posedge CLK);
    end
    if (elem_q.size() != 0 || chk0.pending() != 0) begin
      $display("ERROR: trace and results out of step, %0d trace words and %0d results left",
               elem_q.size(), chk0.pending());
      tb_errors++;
    end
    report_counts();
    if (tb_errors + chk0.mismatch_cnt + chk0.protocol_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb/matrix_diff_checker.sv
//////////////////////////////////////////////////
// Matrix differentiation result checker
// Compares output strobes with queued expectations
//////////////////////////////////////////////////

module matrix_diff_checker #(
  parameter int DATA_SIZE = 16
) (
  input logic                 CLK,
  input logic                 RST,
  input logic                 ready,
  input logic                 dout_i_en,
  input logic                 dout_j_en,
  input logic [DATA_SIZE-1:0] data_out
);

  timeunit 1ns;
  timeprecision 100ps;

  // Expected results in arrival order
  logic [DATA_SIZE-1:0] exp_data_q[$];
  bit                   exp_row_end_q[$];
  bit                   exp_last_q[$];

  // Error and progress counts
  int mismatch_cnt = 0;
  int protocol_cnt = 0;
  int match_cnt    = 0;

  task automatic add_expect(input logic [DATA_SIZE-1:0] data, input bit row_end,
                            input bit last);
    exp_data_q.push_back(data);
    exp_row_end_q.push_back(row_end);
    exp_last_q.push_back(last);
  endtask

  function automatic int pending();
    return exp_data_q.size();
  endfunction

  // DATA_OUT cleared by reset
  always @(negedge RST) begin
    if (data_out !== DATA_SIZE'(0)) begin
      $display("MISMATCH DATA_OUT after reset: expected 0x%h, got 0x%h",
               DATA_SIZE'(0), data_out);
      mismatch_cnt++;
    end
  end

  // Falling edge sampling away from the DUT update
  always @(negedge CLK) begin
    if (!RST) begin
      check_strobes();
    end
  end

  task automatic check_strobes();
    logic [DATA_SIZE-1:0] exp_data;
    bit                   row_end;
    bit                   last;
    if (!dout_j_en) begin
      // Row end and ready only ride on a result
      if (dout_i_en || ready) begin
        $display("ERROR: row-end or ready strobe without a result strobe at %0t", $time);
        protocol_cnt++;
      end
      return;
    end
    if (exp_data_q.size() == 0) begin
      $display("ERROR: result strobe with no element outstanding at %0t", $time);
      protocol_cnt++;
      return;
    end
    exp_data = exp_data_q.pop_front();
    row_end  = exp_row_end_q.pop_front();
    last     = exp_last_q.pop_front();
    if (data_out !== exp_data) begin
      $display("MISMATCH DATA_OUT: expected 0x%h, got 0x%h at %0t", exp_data, data_out, $time);
      mismatch_cnt++;
    end else begin
      match_cnt++;
    end
    if (dout_i_en != row_end) begin
      $display("ERROR: row-end strobe %s at %0t",
               row_end ? "missing on the last column" : "seen before the last column", $time);
      protocol_cnt++;
    end
    if (ready != last) begin
      $display("ERROR: ready strobe %s at %0t",
               last ? "missing on the final element" : "seen before the final element", $time);
      protocol_cnt++;
    end
  endtask

endmodule

// File: hdl/matrix_diff_top.sv
//////////////////////////////////////////////////
// Streaming modular matrix differentiation
// Row-wise discrete derivative modulo M
//////////////////////////////////////////////////

module matrix_diff_top #(
  parameter int DATA_SIZE = diff_pkg::DEF_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic                 DATA_IN_I_ENABLE,
  input  logic                 DATA_IN_J_ENABLE,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] SIZE_I_IN,
  input  logic [DATA_SIZE-1:0] SIZE_J_IN,
  input  logic [DATA_SIZE-1:0] DATA_IN,
  output logic                 READY,
  output logic                 DATA_OUT_I_ENABLE,
  output logic                 DATA_OUT_J_ENABLE,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  // Control to datapath link
  mod_op_if #(.DATA_SIZE(DATA_SIZE)) op_if ();

  // Sequencer
  matrix_diff_ctrl #(
    .DATA_SIZE(DATA_SIZE)
  ) ctrl0 (
    .CLK               (CLK),
    .RST               (RST),
    .START             (START),
    .DATA_IN_I_ENABLE  (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE  (DATA_IN_J_ENABLE),
    .MODULO_IN         (MODULO_IN),
    .SIZE_I_IN         (SIZE_I_IN),
    .SIZE_J_IN         (SIZE_J_IN),
    .DATA_IN           (DATA_IN),
    .READY             (READY),
    .DATA_OUT_I_ENABLE (DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE (DATA_OUT_J_ENABLE),
    .DATA_OUT          (DATA_OUT),
    .op                (op_if.ctrl)
  );

  // Element mod M
  mod_reducer #(
    .DATA_SIZE(DATA_SIZE)
  ) reducer0 (
    .CLK (CLK),
    .RST (RST),
    .op  (op_if.reducer)
  );

  // Difference with previous column
  mod_subtractor #(
    .DATA_SIZE(DATA_SIZE)
  ) sub0 (
    .CLK (CLK),
    .RST (RST),
    .op  (op_if.subtractor)
  );

endmodule

// File: hdl/matrix_diff_ctrl.sv
//////////////////////////////////////////////////
// Matrix differentiation control
// Row/column sequencing, element hand-off
// to the modular datapath, output strobes
//////////////////////////////////////////////////

module matrix_diff_ctrl #(
  parameter int DATA_SIZE = diff_pkg::DEF_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic                 DATA_IN_I_ENABLE,
  input  logic                 DATA_IN_J_ENABLE,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] SIZE_I_IN,
  input  logic [DATA_SIZE-1:0] SIZE_J_IN,
  input  logic [DATA_SIZE-1:0] DATA_IN,
  output logic                 READY,
  output logic                 DATA_OUT_I_ENABLE,
  output logic                 DATA_OUT_J_ENABLE,
  output logic [DATA_SIZE-1:0] DATA_OUT,
  mod_op_if.ctrl               op
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // FSM and counters
  diff_pkg::ctrl_state_e state;
  logic [DATA_SIZE-1:0]  row_cnt;
  logic [DATA_SIZE-1:0]  col_cnt;
  logic                  start_q;

  // Matrix setup and current element
  logic [DATA_SIZE-1:0]  modulo_q;
  logic [DATA_SIZE-1:0]  size_i_q;
  logic [DATA_SIZE-1:0]  size_j_q;
  logic [DATA_SIZE-1:0]  operand_q;
  diff_pkg::elem_pos_e   pos_q;

  // Decodes
  logic launch;
  logic accept;
  logic last_col;
  logic last_row;

  assign launch = (state == diff_pkg::IDLE) && START;

  // Row start takes I enable, later columns take J enable
  assign accept = ((state == diff_pkg::WAIT_ROW) && DATA_IN_I_ENABLE) ||
                  ((state == diff_pkg::WAIT_COL) && DATA_IN_J_ENABLE);

  assign last_col = (col_cnt == size_j_q - 1'b1);
  assign last_row = (row_cnt == size_i_q - 1'b1);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= diff_pkg::IDLE;
      row_cnt           <= '0;
      col_cnt           <= '0;
      start_q           <= 1'b0;
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      DATA_OUT          <= '0;
    end else begin
      // Strobes are single cycle
      start_q           <= 1'b0;
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      case (state)
        diff_pkg::IDLE: begin
          if (launch) begin
            row_cnt <= '0;
            col_cnt <= '0;
            state   <= diff_pkg::WAIT_ROW;
          end
        end
        diff_pkg::WAIT_ROW, diff_pkg::WAIT_COL: begin
          // Datapath is idle here, kick it next cycle
          if (accept) begin
            start_q <= 1'b1;
            state   <= diff_pkg::REDUCE;
          end
        end
        diff_pkg::REDUCE: begin
          // Enables in this state are dropped
          if (op.done) begin
            state <= diff_pkg::EMIT;
          end
        end
        diff_pkg::EMIT: begin
          DATA_OUT          <= op.result;
          DATA_OUT_J_ENABLE <= 1'b1;
          if (last_col) begin
            DATA_OUT_I_ENABLE <= 1'b1;
            if (last_row) begin
              READY <= 1'b1;
              state <= diff_pkg::IDLE;
            end else begin
              row_cnt <= row_cnt + 1'b1;
              col_cnt <= '0;
              state   <= diff_pkg::WAIT_ROW;
            end
          end else begin
            col_cnt <= col_cnt + 1'b1;
            state   <= diff_pkg::WAIT_COL;
          end
        end
        default: begin
          state <= diff_pkg::IDLE;
        end
      endcase
    end
  end

  // Setup captured once per matrix, element on accept
  always_ff @(posedge CLK) begin
    if (launch) begin
      modulo_q <= MODULO_IN;
      size_i_q <= SIZE_I_IN;
      size_j_q <= SIZE_J_IN;
    end
    if (accept) begin
      operand_q <= DATA_IN;
      pos_q     <= (col_cnt == '0) ? diff_pkg::ROW_FIRST : diff_pkg::ROW_NEXT;
    end
  end

  // Datapath request
  assign op.start   = start_q;
  assign op.pos     = pos_q;
  assign op.operand = operand_q;
  assign op.modulo  = modulo_q;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_one_enable : assert property (@(posedge CLK) disable iff (RST)
    (state inside {diff_pkg::WAIT_ROW, diff_pkg::WAIT_COL}) |->
      !(DATA_IN_I_ENABLE && DATA_IN_J_ENABLE));

  // Zero modulus has no defined result
  a_modulo_nonzero : assert property (@(posedge CLK) disable iff (RST)
    launch |-> (MODULO_IN != '0));

  // Datapath answers only an element in flight
  a_done_in_reduce : assert property (@(posedge CLK) disable iff (RST)
    op.done |-> (state == diff_pkg::REDUCE));

endmodule

// File: hdl/mod_subtractor.sv
//////////////////////////////////////////////////
// Modular difference stage
// Subtracts previous reduced element of the row
//////////////////////////////////////////////////

module mod_subtractor #(
  parameter int DATA_SIZE = diff_pkg::DEF_DATA_SIZE
) (
  input logic           CLK,
  input logic           RST,
  mod_op_if.subtractor  op
);

  // Control
  logic done_q;

  // Payload
  logic [DATA_SIZE-1:0] prev_q;
  logic [DATA_SIZE-1:0] result_q;
  logic [DATA_SIZE-1:0] diff;

  // Both operands below modulus, so one add-back covers the wrap
  always_comb begin
    if (op.pos == diff_pkg::ROW_FIRST) begin
      diff = op.reduced;
    end else if (op.reduced >= prev_q) begin
      diff = op.reduced - prev_q;
    end else begin
      // Modulus minus prev is at least 1, sum stays below modulus
      diff = (op.modulo - prev_q) + op.reduced;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      done_q <= 1'b0;
    end else begin
      done_q <= op.reduced_valid;
    end
  end

  // New element becomes the reference for the next column
  always_ff @(posedge CLK) begin
    if (op.reduced_valid) begin
      result_q <= diff;
      prev_q   <= op.reduced;
    end
  end

  assign op.done   = done_q;
  assign op.result = result_q;

  // Whole datapath keeps results in range
  a_result_range : assert property (@(posedge CLK) disable iff (RST)
    op.done |-> (op.result < op.modulo));

endmodule

// File: hdl/mod_reducer.sv
//////////////////////////////////////////////////
// Bit-serial modular reducer
// Restoring shift-and-subtract, MSB first,
// one operand bit per cycle
//////////////////////////////////////////////////

module mod_reducer #(
  parameter int DATA_SIZE = diff_pkg::DEF_DATA_SIZE
) (
  input logic        CLK,
  input logic        RST,
  mod_op_if.reducer  op
);

  localparam int CNT_W = $clog2(DATA_SIZE);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_SIZE - 1);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // Control
  logic             busy;
  logic [CNT_W-1:0] bit_cnt;
  logic             valid_q;

  // Payload
  logic [DATA_SIZE-1:0] shift_q;
  logic [DATA_SIZE-1:0] rem_q;

  // One restoring step
  logic [DATA_SIZE:0]   trial;
  logic [DATA_SIZE-1:0] rem_next;

  //////////////////////////////////////////////////
  // Remainder step
  //////////////////////////////////////////////////

  // First step runs on the start edge with a cleared remainder
  assign trial = op.start ? {{DATA_SIZE{1'b0}}, op.operand[DATA_SIZE-1]}
                          : {rem_q, shift_q[DATA_SIZE-1]};

  // Remainder stays below modulus, so one subtract is enough
  always_comb begin
    if (trial >= {1'b0, op.modulo}) begin
      rem_next = DATA_SIZE'(trial - {1'b0, op.modulo});
    end else begin
      rem_next = trial[DATA_SIZE-1:0];
    end
  end

  // Sequencing
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (op.start) begin
        busy    <= 1'b1;
        bit_cnt <= CNT_W'(1);
      end else if (busy) begin
        bit_cnt <= bit_cnt + 1'b1;
        // Last bit folded in this cycle
        if (bit_cnt == LAST_BIT) begin
          busy    <= 1'b0;
          valid_q <= 1'b1;
        end
      end
    end
  end

  // Operand shift and partial remainder
  always_ff @(posedge CLK) begin
    if (op.start) begin
      shift_q <= op.operand << 1;
      rem_q   <= rem_next;
    end else if (busy) begin
      shift_q <= shift_q << 1;
      rem_q   <= rem_next;
    end
  end

  assign op.reduced       = rem_q;
  assign op.reduced_valid = valid_q;

  // Control must wait for the previous element
  a_no_start_busy : assert property (@(posedge CLK) disable iff (RST)
    busy |-> !op.start);

endmodule

// File: hdl/mod_op_if.sv
//////////////////////////////////////////////////
// Modular datapath link
// Control to reducer to subtractor handshake
//////////////////////////////////////////////////

interface mod_op_if #(
  parameter int DATA_SIZE = diff_pkg::DEF_DATA_SIZE
);

  // Request side, from control
  logic                  start;
  diff_pkg::elem_pos_e   pos;
  logic [DATA_SIZE-1:0]  operand;
  logic [DATA_SIZE-1:0]  modulo;

  // Reducer to subtractor
  logic [DATA_SIZE-1:0]  reduced;
  logic                  reduced_valid;

  // Response side, back to control
  logic                  done;
  logic [DATA_SIZE-1:0]  result;

  modport ctrl (output start, pos, operand, modulo, input done, result);

  modport reducer (input start, operand, modulo, output reduced, reduced_valid);

  modport subtractor (input reduced_valid, reduced, pos, modulo, output done, result);

endinterface

// File: hdl/diff_pkg.sv
//////////////////////////////////////////////////
// Matrix differentiation shared definitions
// Control states, element position, default width
//////////////////////////////////////////////////

package diff_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Default element, modulus and size width
  localparam int DEF_DATA_SIZE = 16;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Control FSM states
  typedef enum logic [2:0] {
    IDLE     = 3'd0,  // Waiting for START
    WAIT_ROW = 3'd1,  // Waiting for first element of a row
    WAIT_COL = 3'd2,  // Waiting for next element of a row
    REDUCE   = 3'd3,  // Element in the datapath
    EMIT     = 3'd4   // Result out, counters advance
  } ctrl_state_e;

  // Position of an element inside its row
  typedef enum logic [0:0] {
    ROW_FIRST = 1'b0,  // Previous element counts as zero
    ROW_NEXT  = 1'b1
  } elem_pos_e;

endpackage
